/* dcache_config.svh */
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// byte address width of the load/store unit
`define DCACHE_ADDR_WIDTH 32

// one line is four 32-bit words
`define DCACHE_LINE_BYTES 16

// small on purpose, so a short trace can force evictions
`define DCACHE_NSET 16

`define DCACHE_NWAY 2

// victim choice
`define DCACHE_LFSR_WIDTH 16

`endif

/* dcache_addr_pkg.sv */
`include "dcache_config.svh"

package dcache_addr_pkg;

    localparam int OFFSET_W = $clog2(`DCACHE_LINE_BYTES);
    localparam int INDEX_W = $clog2(`DCACHE_NSET);
    localparam int TAG_W = `DCACHE_ADDR_WIDTH - INDEX_W - OFFSET_W;

    // byte address as seen by the cpu and the memory port
    typedef logic [`DCACHE_ADDR_WIDTH-1:0] addr_t;

    typedef logic [31:0] word_t;

    typedef logic [8*`DCACHE_LINE_BYTES-1:0] line_t;

    // one enable per byte of a line
    typedef logic [`DCACHE_LINE_BYTES-1:0] line_be_t;

    // address fields, msb to lsb: tag, index, offset
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [OFFSET_W-1:0] offset_t;

endpackage

/* dcache_ctrl_pkg.sv */
`include "dcache_config.svh"

package dcache_ctrl_pkg;

    // all zero on a load
    typedef logic [3:0] wstrb_t;

    typedef logic [$clog2(`DCACHE_NWAY)-1:0] way_t;

    typedef logic [`DCACHE_LFSR_WIDTH-1:0] lfsr_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        REFILL_REQ,
        REFILL_WAIT
    } miss_state_e;

endpackage

/* dcache_way_ram.sv */
`include "dcache_config.svh"

module dcache_way_ram
    import dcache_addr_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     rd_en_i,
    input  index_t   rd_index_i,
    input  index_t   wr_index_i,
    input  logic     tag_we_i,
    input  tag_t     tag_wdata_i,
    input  logic     valid_wdata_i,
    input  logic     dirty_wdata_i,
    input  line_be_t data_be_i,
    input  line_t    data_wdata_i,
    output tag_t     tag_o,
    output logic     valid_o,
    output logic     dirty_o,
    output line_t    data_o
);

    tag_t       tag_mem   [`DCACHE_NSET];
    logic       valid_mem [`DCACHE_NSET];
    logic       dirty_mem [`DCACHE_NSET];
    logic [7:0] data_mem  [`DCACHE_NSET][`DCACHE_LINE_BYTES];

    always_ff @(posedge clk) begin
        if (tag_we_i) begin
            tag_mem[wr_index_i] <= tag_wdata_i;
            valid_mem[wr_index_i] <= valid_wdata_i;
            dirty_mem[wr_index_i] <= dirty_wdata_i;
        end
        for (int b = 0; b < `DCACHE_LINE_BYTES; b++) begin
            if (data_be_i[b]) begin
                data_mem[wr_index_i][b] <= data_wdata_i[b*8 +: 8];
            end
        end
    end

    // outputs hold while the pipeline is stalled
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            tag_o <= tag_mem[rd_index_i];
            valid_o <= valid_mem[rd_index_i];
            dirty_o <= dirty_mem[rd_index_i];
            for (int b = 0; b < `DCACHE_LINE_BYTES; b++) begin
                data_o[b*8 +: 8] <= data_mem[rd_index_i][b];
            end
        end
    end

    // control state in the parent has settled one edge into reset
    assert property (@(posedge clk) rst ##1 rst |-> !tag_we_i && data_be_i == '0)
        else $error("way array written during reset");

endmodule

/* dcache_store_merge.sv */
module dcache_store_merge
    import dcache_addr_pkg::*;
    import dcache_ctrl_pkg::*;
(
    input  line_t    line_i,
    input  offset_t  offset_i,
    input  wstrb_t   wstrb_i,
    input  word_t    wdata_i,
    output line_t    line_o,
    output line_be_t line_be_o
);

    localparam int WORD_BYTES = $bits(wstrb_t);
    localparam int LINE_WORDS = $bits(line_be_t) / WORD_BYTES;
    localparam int SEL_W = $clog2(LINE_WORDS);

    logic [SEL_W-1:0] word_sel;

    // word slot from the upper offset bits
    assign word_sel = offset_i[$bits(offset_t)-1 -: SEL_W];

    always_comb begin
        line_be_o = '0;
        line_be_o[word_sel*WORD_BYTES +: WORD_BYTES] = wstrb_i;
        for (int b = 0; b < $bits(line_be_t); b++) begin
            // store data is lane aligned, so every slot sees the same word
            if (line_be_o[b]) begin
                line_o[b*8 +: 8] = wdata_i[(b % WORD_BYTES)*8 +: 8];
            end else begin
                line_o[b*8 +: 8] = line_i[b*8 +: 8];
            end
        end
    end

    // byte, aligned halfword or full word only
    always_comb begin
        assert final ($isunknown(wstrb_i) || wstrb_i inside {
            4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
            4'b0011, 4'b1100, 4'b1111
        })
            else $error("illegal store strobe %b", wstrb_i);
    end

endmodule

/* dcache_miss_ctrl.sv */
module dcache_miss_ctrl
    import dcache_addr_pkg::*;
    import dcache_ctrl_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   miss_i,
    input  logic   victim_dirty_i,
    input  tag_t   victim_tag_i,
    input  index_t index_i,
    input  addr_t  line_addr_i,
    input  logic   mem_rd_valid_i,
    output logic   busy_o,
    output logic   refill_o,
    output way_t   victim_way_o,
    output logic   mem_rd_req_o,
    output addr_t  mem_rd_addr_o,
    output logic   mem_wr_req_o,
    output addr_t  mem_wr_addr_o
);

    localparam int LFSR_W = $bits(lfsr_t);

    miss_state_e state;
    miss_state_e next_state;
    lfsr_t       lfsr;
    way_t        victim_way_q;

    // x^16 + x^14 + x^13 + x^11 + 1, free running
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= lfsr_t'(16'hace1);
        end else begin
            lfsr <= {lfsr[LFSR_W-2:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (miss_i) begin
                    next_state = WRITEBACK;
                end
            end
            // victim tag and dirty bit are valid here, one cycle after the choice
            WRITEBACK: begin
                next_state = REFILL_REQ;
            end
            REFILL_REQ: begin
                next_state = REFILL_WAIT;
            end
            REFILL_WAIT: begin
                if (mem_rd_valid_i) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // victim is fixed for the whole miss
    always_ff @(posedge clk) begin
        if (rst) begin
            victim_way_q <= '0;
        end else if (state == IDLE && miss_i) begin
            victim_way_q <= lfsr[$bits(way_t)-1:0];
        end
    end

    assign busy_o = state != IDLE;
    assign victim_way_o = victim_way_q;

    // clean victims are dropped without a memory write
    assign mem_wr_req_o = state == WRITEBACK && victim_dirty_i;
    assign mem_wr_addr_o = {victim_tag_i, index_i, offset_t'(0)};

    assign mem_rd_req_o = state == REFILL_REQ;
    assign mem_rd_addr_o = line_addr_i;

    assign refill_o = state == REFILL_WAIT && mem_rd_valid_i;

    assert property (@(posedge clk) disable iff (rst) mem_rd_valid_i |-> state == REFILL_WAIT)
        else $error("refill data without an outstanding read");

endmodule

/* dcache_top.sv */
`include "dcache_config.svh"

module dcache_top
    import dcache_addr_pkg::*;
    import dcache_ctrl_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   req_valid_i,
    input  addr_t  req_addr_i,
    input  wstrb_t req_wstrb_i,
    input  word_t  req_wdata_i,
    output logic   ready_o,
    output logic   resp_valid_o,
    output word_t  resp_rdata_o,
    output logic   mem_rd_req_o,
    output addr_t  mem_rd_addr_o,
    input  logic   mem_rd_valid_i,
    input  line_t  mem_rd_line_i,
    output logic   mem_wr_req_o,
    output addr_t  mem_wr_addr_o,
    output line_t  mem_wr_line_o
);

    localparam int NWAY = `DCACHE_NWAY;
    localparam int WORD_LSB = $clog2($bits(word_t) / 8);

    logic    accept;
    index_t  req_index;
    logic    p2_valid;
    addr_t   p2_addr;
    wstrb_t  p2_wstrb;
    word_t   p2_wdata;
    tag_t    p2_tag;
    index_t  p2_index;
    offset_t p2_offset;

    tag_t  way_tag   [NWAY];
    logic  way_valid [NWAY];
    logic  way_dirty [NWAY];
    line_t way_data  [NWAY];

    logic [NWAY-1:0] hit_way;
    way_t     hit_idx;
    line_t    hit_line;
    logic     hit_valid;
    logic     store_hit;
    logic     miss;
    line_t    hit_merged;
    line_be_t hit_be;
    line_t    refill_merged;

    logic     sweep_on;
    logic     sweep_done;
    index_t   sweep_cnt;
    logic     busy;
    logic     refill;
    way_t     victim_way;
    logic     victim_dirty;
    tag_t     victim_tag;
    logic     wr_en;
    way_t     wr_way;
    index_t   wr_index;
    line_t    wr_line;
    line_be_t wr_be;
    logic     dirty_wdata;
    line_t    resp_line;
    word_t    resp_word;

    assign req_index = req_addr_i[OFFSET_W +: INDEX_W];
    assign p2_tag = p2_addr[OFFSET_W+INDEX_W +: TAG_W];
    assign p2_index = p2_addr[OFFSET_W +: INDEX_W];
    assign p2_offset = p2_addr[OFFSET_W-1:0];

    always_comb begin
        hit_way = '0;
        hit_idx = '0;
        hit_line = way_data[0];
        for (int w = 0; w < NWAY; w++) begin
            hit_way[w] = way_valid[w] && way_tag[w] == p2_tag;
            if (hit_way[w]) begin
                hit_idx = way_t'(w);
                hit_line = way_data[w];
            end
        end
    end

    assign hit_valid = p2_valid && |hit_way;
    assign store_hit = hit_valid && p2_wstrb != '0;
    assign miss = p2_valid && !(|hit_way);

    // a store hit writes the arrays at the end of its compare cycle
    assign ready_o = sweep_done && !busy && !miss && !store_hit;
    assign accept = req_valid_i && ready_o;

    // a missing request stays here until its refill returns
    always_ff @(posedge clk) begin
        if (rst) begin
            p2_valid <= 1'b0;
        end else if (ready_o) begin
            p2_valid <= req_valid_i;
        end else if (store_hit || refill) begin
            p2_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            p2_addr <= req_addr_i;
            p2_wstrb <= req_wstrb_i;
            p2_wdata <= req_wdata_i;
        end
    end

    // clears every valid bit, one set per cycle once reset is released
    always_ff @(posedge clk) begin
        if (rst) begin
            sweep_on <= 1'b0;
            sweep_done <= 1'b0;
            sweep_cnt <= '0;
        end else if (!sweep_done) begin
            sweep_on <= 1'b1;
            if (sweep_on) begin
                sweep_cnt <= sweep_cnt + 1'b1;
                if (sweep_cnt == index_t'(`DCACHE_NSET - 1)) begin
                    sweep_on <= 1'b0;
                    sweep_done <= 1'b1;
                end
            end
        end
    end

    assign wr_en = store_hit || refill;
    assign wr_way = refill ? victim_way : hit_idx;
    assign wr_line = refill ? refill_merged : hit_merged;
    assign wr_be = refill ? '1 : hit_be;
    assign wr_index = sweep_on ? sweep_cnt : p2_index;
    assign dirty_wdata = !sweep_on && p2_wstrb != '0;

    for (genvar w = 0; w < NWAY; w++) begin : g_way
        logic sel;

        assign sel = wr_en && wr_way == way_t'(w);

        dcache_way_ram u_way_ram (
            .clk          (clk),
            .rst          (rst),
            .rd_en_i      (accept),
            .rd_index_i   (req_index),
            .wr_index_i   (wr_index),
            .tag_we_i     (sweep_on || sel),
            .tag_wdata_i  (p2_tag),
            .valid_wdata_i(!sweep_on),
            .dirty_wdata_i(dirty_wdata),
            .data_be_i    (sel ? wr_be : '0),
            .data_wdata_i (wr_line),
            .tag_o        (way_tag[w]),
            .valid_o      (way_valid[w]),
            .dirty_o      (way_dirty[w]),
            .data_o       (way_data[w])
        );
    end

    dcache_store_merge u_hit_merge (
        .line_i   (hit_line),
        .offset_i (p2_offset),
        .wstrb_i  (p2_wstrb),
        .wdata_i  (p2_wdata),
        .line_o   (hit_merged),
        .line_be_o(hit_be)
    );

    // all bytes of a refill are written, so the enables are not needed
    dcache_store_merge u_refill_merge (
        .line_i   (mem_rd_line_i),
        .offset_i (p2_offset),
        .wstrb_i  (p2_wstrb),
        .wdata_i  (p2_wdata),
        .line_o   (refill_merged),
        .line_be_o()
    );

    assign victim_dirty = way_valid[victim_way] && way_dirty[victim_way];
    assign victim_tag = way_tag[victim_way];
    assign mem_wr_line_o = way_data[victim_way];

    dcache_miss_ctrl u_miss_ctrl (
        .clk           (clk),
        .rst           (rst),
        .miss_i        (miss),
        .victim_dirty_i(victim_dirty),
        .victim_tag_i  (victim_tag),
        .index_i       (p2_index),
        .line_addr_i   ({p2_tag, p2_index, offset_t'(0)}),
        .mem_rd_valid_i(mem_rd_valid_i),
        .busy_o        (busy),
        .refill_o      (refill),
        .victim_way_o  (victim_way),
        .mem_rd_req_o  (mem_rd_req_o),
        .mem_rd_addr_o (mem_rd_addr_o),
        .mem_wr_req_o  (mem_wr_req_o),
        .mem_wr_addr_o (mem_wr_addr_o)
    );

    // loads answer from the hit way, or straight from the returning line
    assign resp_valid_o = hit_valid || refill;
    assign resp_line = refill ? mem_rd_line_i : hit_line;
    assign resp_word = resp_line[p2_offset[OFFSET_W-1:WORD_LSB]*$bits(word_t) +: $bits(word_t)];
    assign resp_rdata_o = (resp_valid_o && p2_wstrb == '0) ? resp_word : '0;

    assert property (@(posedge clk) disable iff (rst) !(req_valid_i && !ready_o))
        else $error("request offered while the cache is stalled");

endmodule

/* dcache_checker.sv */
module dcache_checker
    import dcache_addr_pkg::*;
    import dcache_ctrl_pkg::*;
(
    input logic   clk,
    input logic   rst,
    input logic   req_valid_i,
    input addr_t  req_addr_i,
    input wstrb_t req_wstrb_i,
    input logic   ready_i,
    input logic   resp_valid_i,
    input word_t  resp_rdata_i,
    input logic   mem_wr_req_i,
    input addr_t  mem_wr_addr_i
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_ENTRIES = 64;

    int    n_entries = 0;
    int    issued = 0;
    int    responded = 0;
    int    errors = 0;
    int    cycle = 0;
    int    last_accept = -10;
    int    n_stored = 0;
    int    entry_op   [MAX_ENTRIES];
    word_t entry_exp  [MAX_ENTRIES];
    addr_t entry_addr [MAX_ENTRIES];
    addr_t stored_lines [MAX_ENTRIES];
    bit    stored_dirty [MAX_ENTRIES];

    task automatic add_entry(input int op, input addr_t addr, input word_t exp);
        entry_op[n_entries] = op;
        entry_addr[n_entries] = addr;
        entry_exp[n_entries] = exp;
        n_entries++;
    endtask

    // a written-back line stays clean until the trace stores to it again
    function automatic bit clear_dirty_line(input addr_t line_addr);
        bit found;
        found = 1'b0;
        for (int i = 0; i < n_stored; i++) begin
            if (stored_dirty[i] && stored_lines[i] == line_addr) begin
                stored_dirty[i] = 1'b0;
                found = 1'b1;
            end
        end
        return found;
    endfunction

    always @(posedge clk) begin
        cycle++;
        if (!rst && req_valid_i && ready_i) begin
            // an op 2 entry must follow its predecessor by one cycle
            if (issued < n_entries && entry_op[issued] == 2 && last_accept != cycle - 1) begin
                $display("entry %0d was not accepted back-to-back at %0t ns", issued, $time);
                errors++;
            end
            if (req_wstrb_i != '0) begin
                stored_lines[n_stored] = {req_addr_i[31:4], 4'h0};
                stored_dirty[n_stored] = 1'b1;
                n_stored++;
            end
            last_accept = cycle;
            issued++;
        end
        if (!rst && resp_valid_i) begin
            if (responded >= issued || responded >= n_entries) begin
                $display("response at %0t ns has no request waiting for it", $time);
                errors++;
            end else if (resp_rdata_i !== entry_exp[responded]) begin
                $display("** Error at %0t ns: resp_rdata_o expected %h, got %h",
                         $time, entry_exp[responded], resp_rdata_i);
                $display("entry %0d addr %h failed", responded, entry_addr[responded]);
                errors++;
            end else begin
                $display("entry %0d addr %h data %h ok", responded,
                         entry_addr[responded], resp_rdata_i);
            end
            responded++;
        end
        if (!rst && mem_wr_req_i) begin
            if (!clear_dirty_line(mem_wr_addr_i)) begin
                $display("write-back at %0t ns of line %h that holds no stored data",
                         $time, mem_wr_addr_i);
                errors++;
            end
        end
    end

    task automatic report(output int total_errors);
        if (issued != n_entries) begin
            $display("only %0d of %0d requests were issued", issued, n_entries);
            errors++;
        end
        if (responded != issued) begin
            $display("%0d requests issued but %0d responses seen", issued, responded);
            errors++;
        end
        $display("entries %0d, issued %0d, responses %0d, errors %0d",
                 n_entries, issued, responded, errors);
        total_errors = errors;
    endtask

endmodule

/* tb_dcache.sv */
module tb_dcache
    import dcache_addr_pkg::*;
    import dcache_ctrl_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 16;
    localparam int MAX_ENTRIES = 64;

    logic   clk;
    logic   rst;
    logic   req_valid_i;
    addr_t  req_addr_i;
    wstrb_t req_wstrb_i;
    word_t  req_wdata_i;
    logic   ready_o;
    logic   resp_valid_o;
    word_t  resp_rdata_o;
    logic   mem_rd_req_o;
    addr_t  mem_rd_addr_o;
    logic   mem_rd_valid_i;
    line_t  mem_rd_line_i;
    logic   mem_wr_req_o;
    addr_t  mem_wr_addr_o;
    line_t  mem_wr_line_o;

    int     n_entries = 0;
    bit     trace_loaded = 0;
    int     trace_op    [MAX_ENTRIES];
    addr_t  trace_addr  [MAX_ENTRIES];
    wstrb_t trace_wstrb [MAX_ENTRIES];
    word_t  trace_wdata [MAX_ENTRIES];
    word_t  mem_words [addr_t];

    dcache_top dut (.*);

    dcache_checker chk (
        .clk          (clk),
        .rst          (rst),
        .req_valid_i  (req_valid_i),
        .req_addr_i   (req_addr_i),
        .req_wstrb_i  (req_wstrb_i),
        .ready_i      (ready_o),
        .resp_valid_i (resp_valid_o),
        .resp_rdata_i (resp_rdata_o),
        .mem_wr_req_i (mem_wr_req_o),
        .mem_wr_addr_i(mem_wr_addr_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // untouched memory words hold their own byte address
    function automatic line_t read_line(input addr_t base);
        line_t line;
        for (int w = 0; w < 4; w++) begin
            line[w*32 +: 32] = mem_words.exists(base + 4*w) ? mem_words[base + 4*w] : base + 4*w;
        end
        return line;
    endfunction

    initial begin
        int    rd_cnt;
        bit    rd_pending;
        addr_t rd_addr;
        void'($urandom(32'hd43b_a599));
        rd_pending = 0;
        rd_cnt = 0;
        mem_rd_valid_i = 1'b0;
        mem_rd_line_i = '0;
        forever begin
            @(posedge clk);
            mem_rd_valid_i <= 1'b0;
            if (rd_pending) begin
                if (rd_cnt == 1) begin
                    mem_rd_valid_i <= 1'b1;
                    mem_rd_line_i <= read_line(rd_addr);
                    rd_pending = 0;
                end else begin
                    rd_cnt--;
                end
            end
            if (mem_rd_req_o) begin
                rd_pending = 1;
                rd_addr = mem_rd_addr_o;
                rd_cnt = $urandom % 6 + 1;
            end
            if (mem_wr_req_o) begin
                for (int w = 0; w < 4; w++) begin
                    mem_words[mem_wr_addr_o + 4*w] = mem_wr_line_o[w*32 +: 32];
                end
            end
        end
    end

    task automatic read_trace();
        int    fd;
        int    op;
        int    cnt;
        string line;
        addr_t addr;
        wstrb_t wstrb;
        word_t wdata;
        word_t exp;
        fd = $fopen("dcache_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open dcache_trace.txt");
            return;
        end
        while ($fgets(line, fd) > 0) begin
            cnt = $sscanf(line, "%h %h %h %h %h", op, addr, wstrb, wdata, exp);
            if (line.len() > 1 && line.substr(0, 1) != "//" && cnt == 5) begin
                trace_op[n_entries] = op;
                trace_addr[n_entries] = addr;
                trace_wstrb[n_entries] = wstrb;
                trace_wdata[n_entries] = wdata;
                chk.add_entry(op, addr, exp);
                n_entries++;
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int errors;
        int idx;
        int outstanding;
        bit accepted;
        bit offering;
        rst = 1'b1;
        req_valid_i = 1'b0;
        req_addr_i = '0;
        req_wstrb_i = '0;
        req_wdata_i = '0;
        read_trace();
        trace_loaded = 1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        idx = 0;
        outstanding = 0;
        offering = 0;
        while (n_entries > 0 && (idx < n_entries || outstanding != 0 || offering)) begin
            @(posedge clk);
            accepted = req_valid_i && ready_o;
            if (accepted) begin
                outstanding++;
                offering = 0;
                req_valid_i <= 1'b0;
            end
            if (resp_valid_o) begin
                outstanding--;
            end
            // loads marked op 2 go out right behind the previous accept
            if (!offering && idx < n_entries &&
                ((trace_op[idx] == 2 && accepted) ||
                 (outstanding == 0 && (ready_o || resp_valid_o)))) begin
                req_valid_i <= 1'b1;
                req_addr_i <= trace_addr[idx];
                req_wstrb_i <= trace_wstrb[idx];
                req_wdata_i <= trace_wdata[idx];
                offering = 1;
                idx++;
            end
        end
        repeat (5) @(posedge clk);
        chk.report(errors);
        if (n_entries == 0) begin
            $display("trace held no entries");
            errors++;
        end
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        wait (trace_loaded);
        repeat (n_entries * 20 + RESET_CYCLES) @(posedge clk);
        $display("timeout: the trace did not finish in %0d cycles",
                 n_entries * 20 + RESET_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* src.f */
+incdir+.
dcache_addr_pkg.sv
dcache_ctrl_pkg.sv
dcache_way_ram.sv
dcache_store_merge.sv
dcache_miss_ctrl.sv
dcache_top.sv
dcache_checker.sv
tb_dcache.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - include_dirs:
      - .
    files:
      - dcache_addr_pkg.sv
      - dcache_ctrl_pkg.sv
      - dcache_way_ram.sv
      - dcache_store_merge.sv
      - dcache_miss_ctrl.sv
      - dcache_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - dcache_checker.sv
      - tb_dcache.sv

/* dcache_trace.txt */
// op addr wstrb wdata expected, all hex
// op 0 load or store after the previous response, 1 store, 2 load right behind a load hit
0 00001000 0 00000000 00001000
0 00001004 0 00000000 00001004
2 00001008 0 00000000 00001008
2 0000100c 0 00000000 0000100c
1 00001004 1 000000aa 00000000
0 00001004 0 00000000 000010aa
1 00001008 c beef0000 00000000
0 00001008 0 00000000 beef1008
1 0000100c f 12345678 00000000
0 0000100c 0 00000000 12345678
1 00001001 2 00005500 00000000
0 00001000 0 00000000 00005500
1 00002010 3 0000cafe 00000000
0 00002010 0 00000000 0000cafe
0 00002014 0 00000000 00002014
1 00003016 c 77660000 00000000
0 00003014 0 00000000 77663014
1 00002000 f 11112222 00000000
1 00003000 f 33334444 00000000
1 00004000 f 55556666 00000000
0 00001000 0 00000000 00005500
0 00001004 0 00000000 000010aa
0 0000100c 0 00000000 12345678
0 00002000 0 00000000 11112222
0 00003000 0 00000000 33334444
0 00004000 0 00000000 55556666
0 00002004 0 00000000 00002004
0 00004010 0 00000000 00004010
0 00005010 0 00000000 00005010
0 00002010 0 00000000 0000cafe
0 00003014 0 00000000 77663014
1 00003017 8 99000000 00000000
0 00003014 0 00000000 99663014
2 00003010 0 00000000 00003010
0 000000f0 0 00000000 000000f0
1 000000f3 8 ab000000 00000000
0 000000f0 0 00000000 ab0000f0
0 00001008 0 00000000 beef1008
